/* hw/alu_taylor_calc.sv */
// ######################################################################
// Sine and cosine unit for the ALU, five term Taylor series on a Q2.16
// operand within +-pi/2. Pulse do_calc while idle, the answer appears on
// result with a one cycle calc_done pulse taylor_latency cycles later.
// ######################################################################

`timescale 1ns/1ps

module alu_taylor_calc import taylor_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    do_calc,        // start, ignored while busy.
    input  logic [func_w-1:0]       function_sel,   // func_sin or func_cos.
    input  logic signed [fix_w-1:0] x_in,           // Q2.16 operand.
    output logic                    calc_done,      // one cycle pulse.
    output logic signed [fix_w-1:0] result          // Q2.16 answer.
);

    logic              load;
    logic              x2_en;
    logic              term_en;
    logic              sum_en;
    logic [1:0]        mul_sel;
    logic [step_w-1:0] step;
    logic [func_w-1:0] func_code;
    logic              func_valid;
    logic [fix_w-1:0]  coef;

    taylor_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .do_calc    (do_calc),
        .func_valid (func_valid),
        .load       (load),
        .x2_en      (x2_en),
        .term_en    (term_en),
        .sum_en     (sum_en),
        .mul_sel    (mul_sel),
        .step       (step),
        .calc_done  (calc_done)
    );

    taylor_datapath u_dp (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .x2_en        (x2_en),
        .term_en      (term_en),
        .sum_en       (sum_en),
        .mul_sel      (mul_sel),
        .step         (step),
        .function_sel (function_sel),
        .x_in         (x_in),
        .coef         (coef),
        .func_code    (func_code),
        .func_valid   (func_valid),
        .result       (result)
    );

    taylor_coef_rom u_rom (
        .func (func_code),      // latched code, function_sel may move while busy.
        .step (step),
        .coef (coef)
    );

endmodule

/* hw/fix_mul.sv */
// ######################################################################
// Signed Q2.16 multiplier with round to nearest and saturation.
// The product is registered, one cycle after the operands.
// ######################################################################

`timescale 1ns/1ps

module fix_mul import taylor_pkg::*; (
    input  logic                    clk,
    input  logic signed [fix_w-1:0] a,          // Q2.16 operand.
    input  logic signed [fix_w-1:0] b,          // Q2.16 operand.
    output logic signed [fix_w-1:0] p           // registered Q2.16 product.
);

    logic signed [2*fix_w-1:0]        full;     // Q4.32 product.
    logic signed [2*fix_w-1:0]        half_lsb; // half of one output lsb.
    logic signed [2*fix_w-1:0]        rounded;
    logic signed [2*fix_w-frac_w-1:0] scaled;   // Q4.16 before the clamp.
    logic signed [fix_w-1:0]          sat;

    always_comb begin
        full               = a * b;
        half_lsb           = '0;
        half_lsb[frac_w-1] = 1'b1;
        rounded            = full + half_lsb;
        scaled             = rounded[2*fix_w-1:frac_w];   // drop the fraction.
        // in range when the guard bits all copy the sign.
        if ((&scaled[2*fix_w-frac_w-1:fix_w-1]) || !(|scaled[2*fix_w-frac_w-1:fix_w-1])) begin
            sat = scaled[fix_w-1:0];
        end else if (scaled[2*fix_w-frac_w-1]) begin
            sat = {1'b1, {(fix_w-1){1'b0}}};              // clamp to -2.0.
        end else begin
            sat = {1'b0, {(fix_w-1){1'b1}}};              // clamp just under 2.0.
        end
    end

    always_ff @(posedge clk) begin
        p <= sat;
    end

endmodule

/* hw/taylor_coef_rom.sv */
// ######################################################################
// Step factor table for the Taylor series unit, combinational.
// The datapath keeps x*x/2 instead of x*x so the square stays in range,
// so each entry is 2/d for the series denominator d of that step.
// ######################################################################

`timescale 1ns/1ps

module taylor_coef_rom import taylor_pkg::*; (
    input  logic [func_w-1:0] func,      // latched function code.
    input  logic [step_w-1:0] step,      // series step.
    output logic [fix_w-1:0]  coef       // Q2.16 factor for this step.
);

    // round(2/d) in Q2.16.
    function automatic logic [fix_w-1:0] recip2(input int unsigned d);
        int unsigned num;
        num = (2 << frac_w) + d / 2;     // half of d gives round to nearest.
        return fix_w'(num / d);
    endfunction

    always_comb begin
        coef = '0;                       // unsupported codes read zero.
        case (func)
            func_sin: begin
                case (step)
                    2'd0: coef = recip2(6);      // x^3 / 3!.
                    2'd1: coef = recip2(20);     // x^5 / 5!.
                    2'd2: coef = recip2(42);     // x^7 / 7!.
                    default: coef = recip2(72);  // x^9 / 9!.
                endcase
            end
            func_cos: begin
                case (step)
                    2'd0: coef = recip2(2);      // x^2 / 2!, reads exactly 1.0.
                    2'd1: coef = recip2(12);     // x^4 / 4!.
                    2'd2: coef = recip2(30);     // x^6 / 6!.
                    default: coef = recip2(56);  // x^8 / 8!.
                endcase
            end
            default: coef = '0;
        endcase
    end

endmodule

/* hw/taylor_ctrl.sv */
// ######################################################################
// Sequencer for the Taylor series unit.
// One square, then a power and a scale multiply per series step, back to
// back on the shared multiplier, then a tail and a finish cycle.
// ######################################################################

`timescale 1ns/1ps

module taylor_ctrl import taylor_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              do_calc,      // start strobe.
    input  logic              func_valid,   // latched code is sin or cos.
    output logic              load,         // latch operand, init term and sum.
    output logic              x2_en,        // capture x*x/2.
    output logic              term_en,      // capture a finished term.
    output logic              sum_en,       // fold the held term into the sum.
    output logic [1:0]        mul_sel,      // multiplier operand select.
    output logic [step_w-1:0] step,         // series step being worked.
    output logic              calc_done     // one cycle completion pulse.
);

    typedef enum logic [2:0] {
        st_idle,
        st_square,       // x * x/2 issued.
        st_power_x2,     // first power, x*x/2 taken straight from the product.
        st_power,        // term * x*x/2 issued, fresh term captured.
        st_scale,        // product * factor issued, held term summed.
        st_tail,         // last term captured.
        st_finish        // last term summed into the result.
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:     if (do_calc) state_nxt = st_square;   // starts only from idle.
            st_square:   state_nxt = st_power_x2;
            st_power_x2: state_nxt = st_scale;
            st_power:    state_nxt = st_scale;
            st_scale: begin
                if (step == step_w'(n_steps - 1)) begin
                    state_nxt = st_tail;                      // no power after the last scale.
                end else begin
                    state_nxt = st_power;
                end
            end
            st_tail:     state_nxt = st_finish;
            st_finish:   state_nxt = st_idle;
            default:     state_nxt = st_idle;
        endcase
    end

    always_comb begin
        load    = 1'b0;
        x2_en   = 1'b0;
        term_en = 1'b0;
        sum_en  = 1'b0;
        mul_sel = mul_sq;
        case (state)
            st_idle:     load = do_calc;
            st_power_x2: begin
                mul_sel = mul_pow;
                x2_en   = 1'b1;
            end
            st_power: begin
                mul_sel = mul_pow;
                term_en = 1'b1;
            end
            st_scale: begin
                mul_sel = mul_scl;
                sum_en  = (step != '0);      // step 0 has no term waiting yet.
            end
            st_tail:     term_en = 1'b1;
            st_finish:   sum_en  = func_valid;   // low publishes a zero result.
            default:     mul_sel = mul_sq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            step      <= '0;
            calc_done <= 1'b0;
        end else begin
            state     <= state_nxt;
            calc_done <= (state == st_finish);          // high with the new result.
            if (load) begin
                step <= '0;
            end else if (state == st_power) begin
                step <= step + 1'b1;                    // next scale uses the next factor.
            end
        end
    end

endmodule

/* hw/taylor_datapath.sv */
// ######################################################################
// Datapath of the Taylor series unit: operand, x*x/2, term, sum and
// result registers around the shared multiplier.
// Terms from even steps are subtracted and terms from odd steps added.
// ######################################################################

`timescale 1ns/1ps

module taylor_datapath import taylor_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    x2_en,
    input  logic                    term_en,
    input  logic                    sum_en,
    input  logic [1:0]              mul_sel,
    input  logic [step_w-1:0]       step,
    input  logic [func_w-1:0]       function_sel,
    input  logic signed [fix_w-1:0] x_in,
    input  logic [fix_w-1:0]        coef,
    output logic [func_w-1:0]       func_code,    // latched code, drives the factor table.
    output logic                    func_valid,
    output logic signed [fix_w-1:0] result
);

    logic [func_w-1:0]       func_reg;
    logic signed [fix_w-1:0] x_reg;               // operand.
    logic signed [fix_w-1:0] x2_reg;              // x*x/2.
    logic signed [fix_w-1:0] term_reg;            // latest finished term.
    logic                    term_add;            // term sign, set on odd steps.
    logic signed [fix_w-1:0] sum_reg;             // running series sum.
    logic                    fin_q;               // last term is held, publish next.
    logic signed [fix_w-1:0] init_term;
    logic signed [fix_w-1:0] mul_a;
    logic signed [fix_w-1:0] mul_b;
    logic signed [fix_w-1:0] prod;
    logic signed [fix_w:0]   sum_wide;
    logic signed [fix_w-1:0] sum_next;

    assign func_code  = func_reg;
    assign func_valid = (func_reg == func_sin) || (func_reg == func_cos);

    always_comb begin
        case (function_sel)
            func_sin: init_term = x_in;           // sin starts at x.
            func_cos: init_term = fix_one;        // cos starts at 1.0.
            default:  init_term = '0;
        endcase
    end

    always_comb begin
        case (mul_sel)
            mul_pow: begin
                // the first power still has x*x/2 only in the product register.
                mul_a = x2_en ? term_reg : prod;
                mul_b = x2_en ? prod : x2_reg;
            end
            mul_scl: begin
                mul_a = prod;
                mul_b = $signed(coef);
            end
            default: begin
                mul_a = x_reg;
                mul_b = x_reg >>> 1;              // halved so the square fits Q2.16.
            end
        endcase
    end

    fix_mul u_mul (
        .clk (clk),
        .a   (mul_a),
        .b   (mul_b),
        .p   (prod)
    );

    always_comb begin
        if (term_add) begin
            sum_wide = {sum_reg[fix_w-1], sum_reg} + {term_reg[fix_w-1], term_reg};
        end else begin
            sum_wide = {sum_reg[fix_w-1], sum_reg} - {term_reg[fix_w-1], term_reg};
        end
        if (sum_wide[fix_w] == sum_wide[fix_w-1]) begin
            sum_next = sum_wide[fix_w-1:0];
        end else if (sum_wide[fix_w]) begin
            sum_next = {1'b1, {(fix_w-1){1'b0}}};     // saturate low.
        end else begin
            sum_next = {1'b0, {(fix_w-1){1'b1}}};     // saturate high.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            x_reg    <= x_in;
            term_reg <= init_term;
            sum_reg  <= init_term;                // the first term is the sum.
        end else begin
            if (term_en) begin
                term_reg <= prod;
                term_add <= step[0];
            end
            if (sum_en) sum_reg <= sum_next;
        end
        if (x2_en) x2_reg <= prod;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            func_reg <= '0;
            fin_q    <= 1'b0;
            result   <= '0;
        end else begin
            if (load) func_reg <= function_sel;
            fin_q <= term_en && (step == step_w'(n_steps - 1));
            if (fin_q) result <= sum_en ? sum_next : '0;   // held until the next finish.
        end
    end

endmodule

/* hw/taylor_pkg.sv */
// ######################################################################
// Shared constants for the Taylor series sine/cosine unit.
// Modules take these by a wildcard import in their headers.
// ######################################################################

package taylor_pkg;

    // Q2.16 signed fixed point.
    localparam int fix_w  = 18;                      // total width of every value.
    localparam int frac_w = 16;                      // fraction bits.

    // 1.0 in Q2.16.
    localparam logic signed [fix_w-1:0] fix_one = fix_w'(1 << frac_w);

    // function codes on function_sel.
    localparam int func_w = 3;                       // width of the function code.
    localparam logic [func_w-1:0] func_sin = 3'd0;   // sine.
    localparam logic [func_w-1:0] func_cos = 3'd1;   // cosine.

    // series length, the first term comes for free from the operand.
    localparam int n_steps = 4;                      // steps after the first term.
    localparam int step_w  = 2;                      // holds 0 .. n_steps-1.

    // sampling edge of do_calc to the edge that raises calc_done.
    localparam int taylor_latency = 11;

    // multiplier operand select codes, controller to datapath.
    localparam logic [1:0] mul_sq  = 2'd0;           // x times x/2.
    localparam logic [1:0] mul_pow = 2'd1;           // term times x*x/2.
    localparam logic [1:0] mul_scl = 2'd2;           // product times step factor.

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the Taylor series unit testbench with Verilator and runs it.
# Exits 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_alu_taylor_calc \
    -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* tests/alu_taylor_calc_chk.sv */
// ######################################################################
// Assertions on the calc_done timing of the Taylor series unit.
// Bound into alu_taylor_calc by the testbench.
// ######################################################################

`timescale 1ns/1ps

module alu_taylor_calc_chk import taylor_pkg::*; (
    input logic clk,
    input logic rst,
    input logic do_calc,
    input logic calc_done
);

    int   busy_cnt     = 0;      // cycles until the unit takes a start again.
    logic start_q      = 1'b0;   // a start was accepted at the last edge.
    logic seen_start   = 1'b0;   // any start since reset.
    int   fail_pulse   = 0;
    int   fail_latency = 0;
    int   fail_idle    = 0;
    logic accept;

    assign accept = do_calc && (busy_cnt == 0);   // starts while busy are dropped.

    always @(posedge clk) begin
        if (rst) begin
            busy_cnt   <= 0;
            start_q    <= 1'b0;
            seen_start <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                busy_cnt   <= taylor_latency;
                seen_start <= 1'b1;
            end else if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 1;
            end
        end
    end

    // completion is a single cycle pulse.
    pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
        calc_done |=> !calc_done)
        else begin
            fail_pulse = fail_pulse + 1;
            $error("calc_done high on two cycles in a row");
        end

    // done exactly taylor_latency edges after the accepting edge, and never otherwise.
    done_latency: assert property (@(posedge clk) disable iff (rst)
        calc_done == $past(start_q, taylor_latency))
        else begin
            fail_latency = fail_latency + 1;
            $error("calc_done not taylor_latency cycles after an accepted start");
        end

    // quiet after reset until the first start.
    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_start |-> !calc_done)
        else begin
            fail_idle = fail_idle + 1;
            $error("calc_done raised before any start");
        end

endmodule

/* tests/taylor_cases.txt */
# func x expect busy busy_x, all hex; x, expect and busy_x are 18 bit Q2.16 two's complement
# busy 1 sends a second start with busy_x while the unit works, expect is for x
0 00000 00000 0 00000
0 0C910 0B505 0 00000
0 336F0 34AFB 0 00000
0 19220 10000 0 00000
0 26DE0 30000 0 00000
0 10000 0D76B 0 00000
0 30000 32895 0 00000
1 00000 10000 0 00000
1 0C910 0B505 0 00000
1 336F0 0B505 0 00000
1 19220 00000 0 00000
1 26DE0 00000 0 00000
1 10000 08A51 0 00000
1 30000 08A51 0 00000
2 0C910 00000 0 00000
3 19220 00000 0 00000
4 10000 00000 0 00000
5 336F0 00000 0 00000
6 30000 00000 0 00000
7 26DE0 00000 0 00000
0 10000 0D76B 1 30000
1 0C910 0B505 1 19220

/* tests/tb_alu_taylor_calc.sv */
// ######################################################################
// Testbench for the Taylor series sine/cosine unit. Each case of the
// case file starts one operation, the result is checked against the
// true function value, along with latency, pulse width and hold.
// ######################################################################

`timescale 1ns/1ps

module tb_alu_taylor_calc import taylor_pkg::*; ();

    localparam int    tol_lsb   = 8;                        // allowed error on sin and cos.
    localparam int    max_gap   = 8;                        // longest idle gap between cases.
    localparam int    stray_at  = 3;                        // busy cycle of the stray start.
    localparam string case_file = "tests/taylor_cases.txt";

    logic                    clk;
    logic                    rst;
    logic                    do_calc;
    logic [func_w-1:0]       function_sel;
    logic signed [fix_w-1:0] x_in;
    logic                    calc_done;
    logic signed [fix_w-1:0] result;

    logic [func_w-1:0] c_func[$];     // function code per case.
    logic [fix_w-1:0]  c_x[$];        // operand.
    logic [fix_w-1:0]  c_want[$];     // true value, Q2.16.
    bit                c_stray[$];    // second start while busy.
    logic [fix_w-1:0]  c_stray_x[$];  // operand of that start.

    logic signed [fix_w-1:0] last_result;   // value result has to hold.
    int n_pass;
    int n_fail;
    int n_err;
    int case_errs;
    int chk_fails;
    int cycle_cnt;
    int cycle_limit = 0;

    alu_taylor_calc DUT (
        .clk          (clk),
        .rst          (rst),
        .do_calc      (do_calc),
        .function_sel (function_sel),
        .x_in         (x_in),
        .calc_done    (calc_done),
        .result       (result)
    );

    bind alu_taylor_calc alu_taylor_calc_chk u_chk (
        .clk       (clk),
        .rst       (rst),
        .do_calc   (do_calc),
        .calc_done (calc_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period.
    end

    task automatic count_error();
        n_err     = n_err + 1;
        case_errs = case_errs + 1;
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        int    f;
        int    x;
        int    want;
        int    stray;
        int    stray_x;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", case_file);
            count_error();
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == 8'h23 || line[0] == 8'h0a) continue;
            n = $sscanf(line, "%h %h %h %h %h", f, x, want, stray, stray_x);
            if (n != 5) begin
                $display("malformed line in case file: %s", line);
                count_error();
            end else begin
                c_func.push_back(func_w'(f));
                c_x.push_back(fix_w'(x));
                c_want.push_back(fix_w'(want));
                c_stray.push_back(stray != 0);
                c_stray_x.push_back(fix_w'(stray_x));
            end
        end
        $fclose(fd);
    endtask

    // one idle cycle, no done and result unchanged.
    task automatic idle_cycle();
        @(negedge clk);
        if (calc_done) begin
            $display("calc_done pulsed with no start pending");
            count_error();
        end
        if (result !== last_result) begin
            $display("error: result 0x%05h changed while idle, held 0x%05h", result, last_result);
            count_error();
        end
    endtask

    task automatic run_case(input int idx);
        int                      cycles;
        bit                      done_seen;
        bit                      exact;
        int                      diff;
        logic signed [fix_w-1:0] want;
        case_errs    = 0;
        want         = c_want[idx];
        function_sel = c_func[idx];
        x_in         = c_x[idx];
        do_calc      = 1'b1;
        @(negedge clk);                             // sampled at the edge just passed.
        do_calc      = 1'b0;
        function_sel = ~c_func[idx];                // unit works from its latched copies.
        x_in         = ~c_x[idx];
        cycles       = 0;
        done_seen    = 1'b0;
        while (!done_seen && cycles < 2 * taylor_latency) begin
            @(negedge clk);
            cycles  = cycles + 1;
            do_calc = c_stray[idx] && (cycles == stray_at);
            if (do_calc) x_in = c_stray_x[idx];     // must be dropped, unit is busy.
            if (calc_done) begin
                done_seen = 1'b1;
            end else if (result !== last_result) begin
                $display("error: result 0x%05h changed before calc_done, held 0x%05h",
                         result, last_result);
                count_error();
            end
        end
        if (!done_seen) begin
            $display("case %0d: calc_done never came within %0d cycles", idx, cycles);
            count_error();
        end else if (cycles != taylor_latency) begin
            $display("case %0d: calc_done came %0d cycles after the start, not %0d",
                     idx, cycles, taylor_latency);
            count_error();
        end
        // zero operand and unsupported codes give exact answers.
        exact = ((c_func[idx] != func_sin) && (c_func[idx] != func_cos)) || (c_x[idx] == '0);
        diff  = int'(result) - int'(want);
        if ((exact && diff != 0) || (!exact && (diff > tol_lsb || diff < -tol_lsb))) begin
            $display("error: result got 0x%05h expected 0x%05h", result, want);
            count_error();
        end
        last_result = result;
        @(negedge clk);
        if (calc_done) begin
            $display("case %0d: calc_done stayed high for a second cycle", idx);
            count_error();
        end
        $display("case %0d func %0d x 0x%05h result 0x%05h want 0x%05h latency %0d %s",
                 idx, c_func[idx], c_x[idx], last_result, want, cycles,
                 (case_errs == 0) ? "ok" : "bad");
        if (case_errs == 0) n_pass = n_pass + 1;
        else n_fail = n_fail + 1;
    endtask

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout, run still going after %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int gap;
        void'($urandom(32'hbe22_18c6));             // seeds the idle gaps.
        rst          = 1'b1;
        do_calc      = 1'b0;
        function_sel = '0;
        x_in         = '0;
        n_pass       = 0;
        n_fail       = 0;
        n_err        = 0;
        case_errs    = 0;
        last_result  = '0;
        read_cases();
        cycle_limit = c_func.size() * (taylor_latency + max_gap + 4);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (calc_done !== 1'b0) begin
            $display("calc_done high right after reset");
            count_error();
        end
        if (result !== '0) begin
            $display("error: result got 0x%05h after reset, expected 0x00000", result);
            count_error();
        end
        if (c_func.size() == 0) begin
            $display("no cases read from %s", case_file);
            count_error();
        end
        for (int i = 0; i < c_func.size(); i++) begin
            run_case(i);
            if (c_stray[i]) gap = max_gap;           // room for a wrongly taken second start.
            else gap = int'($urandom % (max_gap + 1));
            repeat (gap) idle_cycle();
        end
        chk_fails = DUT.u_chk.fail_pulse + DUT.u_chk.fail_latency + DUT.u_chk.fail_idle;
        $display("cases %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 c_func.size(), n_pass, n_fail, n_err, chk_fails);
        if (n_fail == 0 && n_err == 0 && chk_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/taylor_pkg.sv
hw/taylor_coef_rom.sv
hw/fix_mul.sv
hw/taylor_ctrl.sv
hw/taylor_datapath.sv
hw/alu_taylor_calc.sv
tests/alu_taylor_calc_chk.sv
tests/tb_alu_taylor_calc.sv
